// ==== build.f ====
source/flash_geom_pkg.sv
source/flash_cmd_pkg.sv
source/update_fsm.sv
source/update_counters.sv
source/update_addr_gen.sv
source/pack_fifo.sv
source/flash_cmd_port.sv
source/flash_update_top.sv
tests/tb_clock.sv
tests/tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_top -f build.f -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "^sim passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tests/tb_top.sv ====
`default_nettype none

module tb_top;
    import flash_geom_pkg::*;
    import flash_cmd_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int NUM_OPS      = 10;
    localparam int WORST_CYCLES = 3000;
    localparam logic [31:0] UNLOCK_MARK = 32'hffff_ffff;

    logic                    clk_i;
    logic                    rst_i;
    logic                    erase_req_i;
    logic                    erase_ack_o;
    logic [7:0]              erase_status_o;
    logic                    pack_vld_i;
    logic [HOST_DATA_W-1:0]  pack_data_i;
    logic                    pack_ready_o;
    logic                    pack_req_i;
    logic [PACK_NUM_W-1:0]   pack_num_i;
    logic                    pack_ack_o;
    logic                    pack_err_o;
    logic                    flash_req_o;
    logic                    flash_ack_i;
    flash_cmd_t              flash_cmd_o;
    logic [FLASH_ADDR_W-1:0] flash_addr_o;
    logic [FLASH_DATA_W-1:0] flash_data_o;
    logic [7:0]              flash_status_i;

    // flash model state
    logic [FLASH_DATA_W-1:0] flash_mem [logic [FLASH_ADDR_W-1:0]];
    logic [31:0]             erase_log [$];
    int                      prog_cmds;
    int                      busy_left;
    logic [7:0]              outcome;
    int                      inject_block;
    logic [7:0]              inject_status;

    logic [31:0]             lfsr_state;
    logic [PACK_NUM_W-1:0]   exp_num;
    int                      errors;
    int                      checks;

    tb_clock #(.PERIOD(CLK_PERIOD)) u_clock (.clk_o(clk_i));

    flash_update_top uut (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .erase_req_i    (erase_req_i),
        .erase_ack_o    (erase_ack_o),
        .erase_status_o (erase_status_o),
        .pack_vld_i     (pack_vld_i),
        .pack_data_i    (pack_data_i),
        .pack_ready_o   (pack_ready_o),
        .pack_req_i     (pack_req_i),
        .pack_num_i     (pack_num_i),
        .pack_ack_o     (pack_ack_o),
        .pack_err_o     (pack_err_o),
        .flash_req_o    (flash_req_o),
        .flash_ack_i    (flash_ack_i),
        .flash_cmd_o    (flash_cmd_o),
        .flash_addr_o   (flash_addr_o),
        .flash_data_o   (flash_data_o),
        .flash_status_i (flash_status_i)
    );

    //////////////////////////////
    // random source

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] block_addr(input int b);
        return 32'(REGION_BASE) + 32'(b) * 32'(BLOCK_WORDS);
    endfunction

    task automatic fail_check(input string msg);
        errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    //////////////////////////////
    // flash model behind the command port

    initial begin : flash_model
        int          delay;
        logic [7:0]  st;
        forever begin
            @(posedge clk_i);
            if (!rst_i && flash_req_o) begin
                delay = 1 + int'(rand_bits(2));
                st    = 8'h00;
                repeat (delay - 1) @(posedge clk_i);
                case (flash_cmd_o)
                    CMD_PROGRAM: begin
                        flash_mem[flash_addr_o] = flash_data_o;
                        prog_cmds++;
                    end
                    CMD_BLOCK_ERASE: begin
                        erase_log.push_back(32'(flash_addr_o));
                        busy_left = int'(rand_bits(2));
                        outcome   = 8'h80;
                        if (inject_status != 8'h00 &&
                            32'(flash_addr_o) == block_addr(inject_block)) begin
                            outcome = inject_status;
                            // a lock is reported only once
                            if (inject_status == 8'h82) begin
                                inject_status = 8'h00;
                            end
                        end
                    end
                    CMD_UNLOCK: erase_log.push_back(UNLOCK_MARK);
                    CMD_READ_STATUS: begin
                        if (busy_left > 0) begin
                            busy_left--;
                        end else begin
                            st = outcome;
                        end
                    end
                    default: ;
                endcase
                flash_ack_i    <= 1'b1;
                flash_status_i <= st;
                do @(posedge clk_i); while (flash_req_o);
                flash_ack_i    <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // host side tasks

    task automatic do_erase(input int blk, input logic [7:0] inj);
        logic [31:0] exp_q [$];
        logic [7:0]  exp_status;
        exp_status = 8'h80;
        for (int b = 0; b < ERASE_BLOCKS; b++) begin
            exp_q.push_back(block_addr(b));
            if (b == blk && inj == 8'h82) begin
                exp_q.push_back(UNLOCK_MARK);
                exp_q.push_back(block_addr(b));
            end else if (b == blk && inj != 8'h00) begin
                exp_status = inj;
                break;
            end
        end
        inject_block  = blk;
        inject_status = inj;
        erase_log.delete();
        erase_req_i <= 1'b1;
        do @(posedge clk_i); while (!erase_ack_o);
        checks++;
        if (erase_status_o !== exp_status) begin
            fail_check($sformatf("erase status %h, expected %h", erase_status_o, exp_status));
        end
        checks++;
        if (erase_log.size() != exp_q.size()) begin
            fail_check($sformatf("%0d erase/unlock commands, expected %0d",
                                 erase_log.size(), exp_q.size()));
        end else begin
            foreach (exp_q[i]) begin
                if (erase_log[i] !== exp_q[i]) begin
                    fail_check($sformatf("erase entry %0d is %h, expected %h",
                                         i, erase_log[i], exp_q[i]));
                end
            end
        end
        repeat (2) begin
            @(posedge clk_i);
            if (!erase_ack_o) fail_check("erase ack dropped while request high");
        end
        erase_req_i <= 1'b0;
        do @(posedge clk_i); while (erase_ack_o);
        exp_num = '0;
    endtask

    task automatic send_packet(input logic [PACK_NUM_W-1:0] num);
        logic [HOST_DATA_W-1:0]  words [PACK_HOST_WORDS];
        logic                    good;
        int                      progs_before;
        logic [FLASH_ADDR_W-1:0] a;
        good = num == exp_num;
        for (int i = 0; i < PACK_HOST_WORDS; i++) begin
            words[i] = rand_bits(32);
            pack_vld_i  <= 1'b1;
            pack_data_i <= words[i];
            do @(posedge clk_i); while (!pack_ready_o);
        end
        pack_vld_i   <= 1'b0;
        progs_before = prog_cmds;
        pack_req_i   <= 1'b1;
        pack_num_i   <= num;
        do @(posedge clk_i); while (!pack_ack_o);
        checks++;
        if (pack_err_o !== !good) begin
            fail_check($sformatf("packet %0d err %b, expected %b", num, pack_err_o, !good));
        end
        checks++;
        if (good) begin
            if (prog_cmds - progs_before != PACK_FLASH_WORDS) begin
                fail_check($sformatf("packet %0d issued %0d program commands",
                                     num, prog_cmds - progs_before));
            end
            for (int i = 0; i < PACK_HOST_WORDS; i++) begin
                a = REGION_BASE + FLASH_ADDR_W'(32'(num) * 16 + 32'(2 * i));
                if (!flash_mem.exists(a) || flash_mem[a] !== words[i][15:0] ||
                    flash_mem[a + 1'b1] !== words[i][31:16]) begin
                    fail_check($sformatf("packet %0d word %0d wrong at %h", num, i, a));
                end
            end
            exp_num++;
        end else begin
            if (prog_cmds != progs_before) begin
                fail_check($sformatf("rejected packet %0d was programmed", num));
            end
            exp_num = '0;
        end
        repeat (2) begin
            @(posedge clk_i);
            if (!pack_ack_o) fail_check("packet ack dropped while request high");
        end
        pack_req_i <= 1'b0;
        do @(posedge clk_i); while (pack_ack_o);
    endtask

    //////////////////////////////
    // watchdog

    initial begin
        #(NUM_OPS * WORST_CYCLES * CLK_PERIOD);
        $display("timeout: the DUT stopped answering a handshake");
        $display("sim failed");
        $finish;
    end

    initial begin
        lfsr_state     = 32'hfa93_8bc6;
        errors         = 0;
        checks         = 0;
        prog_cmds      = 0;
        busy_left      = 0;
        outcome        = 8'h80;
        inject_block   = -1;
        inject_status  = 8'h00;
        exp_num        = '0;
        rst_i          = 1'b1;
        erase_req_i    = 1'b0;
        pack_vld_i     = 1'b0;
        pack_data_i    = '0;
        pack_req_i     = 1'b0;
        pack_num_i     = '0;
        flash_ack_i    = 1'b0;
        flash_status_i = 8'h00;
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;
        @(posedge clk_i);
        checks++;
        if (erase_ack_o || pack_ack_o || flash_req_o || !pack_ready_o) begin
            fail_check("outputs not at their reset values");
        end

        do_erase(-1, 8'h00);
        do_erase(int'(rand_bits(2)), 8'h82);
        do_erase(int'(rand_bits(2)), rand_bits(1) ? 8'hb0 : 8'ha0);

        send_packet(16'd0);
        send_packet(16'd1);
        send_packet(16'd2);
        send_packet(16'd5);
        send_packet(16'd0);
        send_packet(16'd1);

        repeat (4) @(posedge clk_i);
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 4
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== source/flash_update_top.sv ====
`default_nettype none

module flash_update_top (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    // host erase
    input  logic                                  erase_req_i,
    output logic                                  erase_ack_o,
    output logic [7:0]                            erase_status_o,
    // host packet data and handshake
    input  logic                                  pack_vld_i,
    input  logic [flash_geom_pkg::HOST_DATA_W-1:0]  pack_data_i,
    output logic                                  pack_ready_o,
    input  logic                                  pack_req_i,
    input  logic [flash_geom_pkg::PACK_NUM_W-1:0]   pack_num_i,
    output logic                                  pack_ack_o,
    output logic                                  pack_err_o,
    // flash command port
    output logic                                  flash_req_o,
    input  logic                                  flash_ack_i,
    output flash_cmd_pkg::flash_cmd_t             flash_cmd_o,
    output logic [flash_geom_pkg::FLASH_ADDR_W-1:0] flash_addr_o,
    output logic [flash_geom_pkg::FLASH_DATA_W-1:0] flash_data_o,
    input  logic [7:0]                            flash_status_i
);
    import flash_geom_pkg::*;
    import flash_cmd_pkg::*;

    flash_cmd_t              cmd_code;
    logic                    cmd_start;
    logic                    cmd_done;
    logic [7:0]              status;
    logic                    poll_wait;
    logic                    poll_due;
    logic                    pack_done;
    logic                    block_next;
    logic                    last_block;
    logic                    word_next;
    logic                    pack_accept;
    logic                    pack_num_match;
    logic                    fifo_flush;
    logic                    fifo_push;
    logic                    fifo_pop;
    logic                    fifo_full;
    logic [HOST_DATA_W-1:0]  fifo_data;
    logic [FLASH_ADDR_W-1:0] erase_addr;
    logic [FLASH_ADDR_W-1:0] prog_addr;

    //////////////////////////////
    // host side glue

    assign pack_ready_o = !fifo_full;
    assign fifo_push    = pack_vld_i && !fifo_full;

    update_fsm u_fsm (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .erase_req_i      (erase_req_i),
        .pack_req_i       (pack_req_i),
        .pack_num_match_i (pack_num_match),
        .cmd_done_i       (cmd_done),
        .status_i         (status),
        .poll_due_i       (poll_due),
        .pack_done_i      (pack_done),
        .last_block_i     (last_block),
        .cmd_start_o      (cmd_start),
        .cmd_code_o       (cmd_code),
        .poll_wait_o      (poll_wait),
        .block_next_o     (block_next),
        .pack_accept_o    (pack_accept),
        .fifo_flush_o     (fifo_flush),
        .erase_ack_o      (erase_ack_o),
        .erase_status_o   (erase_status_o),
        .pack_ack_o       (pack_ack_o),
        .pack_err_o       (pack_err_o)
    );

    // words of a packet are counted while its request is up
    update_counters u_counters (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .poll_wait_i   (poll_wait),
        .cmd_done_i    (word_next),
        .prog_active_i (pack_req_i),
        .poll_due_o    (poll_due),
        .pack_done_o   (pack_done)
    );

    // a finished erase restarts both the block walk and the packet sequence
    update_addr_gen u_addr_gen (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .erase_start_i    (erase_ack_o),
        .block_next_i     (block_next),
        .word_next_i      (word_next),
        .pack_accept_i    (pack_accept),
        .pack_reset_i     (fifo_flush),
        .pack_num_i       (pack_num_i),
        .erase_addr_o     (erase_addr),
        .prog_addr_o      (prog_addr),
        .pack_num_match_o (pack_num_match),
        .last_block_o     (last_block)
    );

    pack_fifo u_fifo (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .flush_i     (fifo_flush),
        .push_i      (fifo_push),
        .push_data_i (pack_data_i),
        .pop_i       (fifo_pop),
        .pop_data_o  (fifo_data),
        .full_o      (fifo_full),
        .empty_o     ()
    );

    flash_cmd_port u_port (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .cmd_start_i    (cmd_start),
        .cmd_code_i     (cmd_code),
        .erase_addr_i   (erase_addr),
        .prog_addr_i    (prog_addr),
        .fifo_data_i    (fifo_data),
        .flash_ack_i    (flash_ack_i),
        .flash_status_i (flash_status_i),
        .fifo_pop_o     (fifo_pop),
        .cmd_done_o     (cmd_done),
        .status_o       (status),
        .word_next_o    (word_next),
        .busy_o         (),
        .flash_req_o    (flash_req_o),
        .flash_cmd_o    (flash_cmd_o),
        .flash_addr_o   (flash_addr_o),
        .flash_data_o   (flash_data_o)
    );

endmodule

`default_nettype wire

// ==== source/flash_cmd_port.sv ====
`default_nettype none

module flash_cmd_port (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  cmd_start_i,
    input  flash_cmd_pkg::flash_cmd_t             cmd_code_i,
    input  logic [flash_geom_pkg::FLASH_ADDR_W-1:0] erase_addr_i,
    input  logic [flash_geom_pkg::FLASH_ADDR_W-1:0] prog_addr_i,
    input  logic [flash_geom_pkg::HOST_DATA_W-1:0]  fifo_data_i,
    input  logic                                  flash_ack_i,
    input  logic [7:0]                            flash_status_i,
    output logic                                  fifo_pop_o,
    output logic                                  cmd_done_o,
    output logic [7:0]                            status_o,
    output logic                                  word_next_o,
    output logic                                  busy_o,
    output logic                                  flash_req_o,
    output flash_cmd_pkg::flash_cmd_t             flash_cmd_o,
    output logic [flash_geom_pkg::FLASH_ADDR_W-1:0] flash_addr_o,
    output logic [flash_geom_pkg::FLASH_DATA_W-1:0] flash_data_o
);
    import flash_geom_pkg::*;
    import flash_cmd_pkg::*;

    typedef enum logic [1:0] {P_IDLE, P_REQ, P_ACK_LOW, P_DONE} port_state_t;

    port_state_t           pstate;
    logic                  hi_half;
    logic                  launch;
    logic [FLASH_DATA_W-1:0] hi_word;

    assign launch     = pstate == P_IDLE && cmd_start_i;
    assign fifo_pop_o = launch && cmd_code_i == CMD_PROGRAM && !hi_half;
    assign busy_o     = pstate != P_IDLE;
    assign cmd_done_o = pstate == P_DONE;
    assign word_next_o = cmd_done_o && flash_cmd_o == CMD_PROGRAM;

    //////////////////////////////
    // four-phase handshake

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pstate      <= P_IDLE;
            flash_req_o <= 1'b0;
            hi_half     <= 1'b0;
        end else begin
            case (pstate)
                P_IDLE: begin
                    if (cmd_start_i) begin
                        pstate      <= P_REQ;
                        flash_req_o <= 1'b1;
                        if (cmd_code_i == CMD_PROGRAM) begin
                            hi_half <= !hi_half;
                        end
                    end
                end
                P_REQ: begin
                    if (flash_ack_i) begin
                        pstate      <= P_ACK_LOW;
                        flash_req_o <= 1'b0;
                    end
                end
                P_ACK_LOW: if (!flash_ack_i) pstate <= P_DONE;
                default:   pstate <= P_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // command payload, low half goes out first

    always_ff @(posedge clk_i) begin
        if (launch) begin
            flash_cmd_o  <= cmd_code_i;
            flash_addr_o <= (cmd_code_i == CMD_PROGRAM) ? prog_addr_i : erase_addr_i;
            if (fifo_pop_o) begin
                flash_data_o <= fifo_data_i[FLASH_DATA_W-1:0];
                hi_word      <= fifo_data_i[HOST_DATA_W-1:FLASH_DATA_W];
            end else if (cmd_code_i == CMD_PROGRAM) begin
                flash_data_o <= hi_word;
            end else begin
                flash_data_o <= '0;
            end
        end
        if (pstate == P_REQ && flash_ack_i && flash_cmd_o == CMD_READ_STATUS) begin
            status_o <= flash_status_i;
        end
    end

    // a new request waits until the flash has released its ack
    a_req_after_ack_low: assert property (@(posedge clk_i) disable iff (rst_i)
        $rose(flash_req_o) |-> !flash_ack_i);

endmodule

`default_nettype wire

// ==== source/pack_fifo.sv ====
`default_nettype none

module pack_fifo (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic                                 flush_i,
    input  logic                                 push_i,
    input  logic [flash_geom_pkg::HOST_DATA_W-1:0] push_data_i,
    input  logic                                 pop_i,
    output logic [flash_geom_pkg::HOST_DATA_W-1:0] pop_data_o,
    output logic                                 full_o,
    output logic                                 empty_o
);
    import flash_geom_pkg::*;

    logic [HOST_DATA_W-1:0] mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0]  wr_ptr;
    logic [FIFO_PTR_W-1:0]  rd_ptr;
    logic [FIFO_PTR_W:0]    count;

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // show-ahead read
    assign pop_data_o = mem[rd_ptr];
    assign full_o     = count == (FIFO_PTR_W + 1)'(FIFO_DEPTH);
    assign empty_o    = count == '0;

    a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
        push_i |-> !full_o);
    a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
        pop_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== source/update_addr_gen.sv ====
`default_nettype none

module update_addr_gen (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  erase_start_i,
    input  logic                                  block_next_i,
    input  logic                                  word_next_i,
    input  logic                                  pack_accept_i,
    input  logic                                  pack_reset_i,
    input  logic [flash_geom_pkg::PACK_NUM_W-1:0]   pack_num_i,
    output logic [flash_geom_pkg::FLASH_ADDR_W-1:0] erase_addr_o,
    output logic [flash_geom_pkg::FLASH_ADDR_W-1:0] prog_addr_o,
    output logic                                  pack_num_match_o,
    output logic                                  last_block_o
);
    import flash_geom_pkg::*;

    logic [PACK_NUM_W-1:0]   expected;
    logic [FLASH_ADDR_W-1:0] prog_base;
    logic [WORD_IDX_W-1:0]   word_idx;

    // erase walks the region one block at a time
    always_ff @(posedge clk_i) begin
        if (rst_i || erase_start_i) begin
            erase_addr_o <= REGION_BASE;
        end else if (block_next_i) begin
            erase_addr_o <= erase_addr_o + BLOCK_WORDS;
        end
    end

    assign last_block_o = erase_addr_o == LAST_BLOCK_ADDR;

    // packet base is fixed on accept, then expected moves on
    always_ff @(posedge clk_i) begin
        if (rst_i || erase_start_i || pack_reset_i) begin
            expected <= '0;
        end else if (pack_accept_i) begin
            expected  <= expected + 1'b1;
            prog_base <= REGION_BASE + FLASH_ADDR_W'(expected) * FLASH_ADDR_W'(PACK_FLASH_WORDS);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || pack_accept_i) begin
            word_idx <= '0;
        end else if (word_next_i) begin
            word_idx <= word_idx + 1'b1;
        end
    end

    assign prog_addr_o      = prog_base + FLASH_ADDR_W'(word_idx);
    assign pack_num_match_o = pack_num_i == expected;

endmodule

`default_nettype wire

// ==== source/update_counters.sv ====
`default_nettype none

module update_counters (
    input  logic clk_i,
    input  logic rst_i,
    input  logic poll_wait_i,
    input  logic cmd_done_i,
    input  logic prog_active_i,
    output logic poll_due_o,
    output logic pack_done_o
);
    import flash_geom_pkg::*;

    logic [POLL_CNT_W-1:0] poll_cnt;
    logic [WORD_IDX_W:0]   word_cnt;

    // poll timer, restarts whenever the wait is left
    always_ff @(posedge clk_i) begin
        if (rst_i || !poll_wait_i) begin
            poll_cnt   <= '0;
            poll_due_o <= 1'b0;
        end else if (poll_cnt == POLL_CNT_W'(POLL_CYCLES - 1)) begin
            poll_cnt   <= '0;
            poll_due_o <= 1'b1;
        end else begin
            poll_cnt   <= poll_cnt + 1'b1;
            poll_due_o <= 1'b0;
        end
    end

    // completed program commands of the current packet
    always_ff @(posedge clk_i) begin
        if (rst_i || !prog_active_i) begin
            word_cnt <= '0;
        end else if (cmd_done_i) begin
            word_cnt <= word_cnt + 1'b1;
        end
    end

    assign pack_done_o = word_cnt == (WORD_IDX_W + 1)'(PACK_FLASH_WORDS);

endmodule

`default_nettype wire

// ==== source/update_fsm.sv ====
`default_nettype none

module update_fsm (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      erase_req_i,
    input  logic                      pack_req_i,
    input  logic                      pack_num_match_i,
    input  logic                      cmd_done_i,
    input  logic [7:0]                status_i,
    input  logic                      poll_due_i,
    input  logic                      pack_done_i,
    input  logic                      last_block_i,
    output logic                      cmd_start_o,
    output flash_cmd_pkg::flash_cmd_t cmd_code_o,
    output logic                      poll_wait_o,
    output logic                      block_next_o,
    output logic                      pack_accept_o,
    output logic                      fifo_flush_o,
    output logic                      erase_ack_o,
    output logic [7:0]                erase_status_o,
    output logic                      pack_ack_o,
    output logic                      pack_err_o
);
    import flash_cmd_pkg::*;

    upd_state_t state;
    logic       cmd_pend;
    logic       issue_state;
    logic       status_err;
    logic       pack_start;

    //////////////////////////////
    // command per state

    always_comb begin
        issue_state = 1'b1;
        cmd_code_o  = CMD_CLR_STATUS;
        case (state)
            S_CLR:       cmd_code_o = CMD_CLR_STATUS;
            S_ERASE:     cmd_code_o = CMD_BLOCK_ERASE;
            S_RD_STATUS: cmd_code_o = CMD_READ_STATUS;
            S_UNLOCK:    cmd_code_o = CMD_UNLOCK;
            S_PROG:      cmd_code_o = CMD_PROGRAM;
            default:     issue_state = 1'b0;
        endcase
    end

    // one command in flight, none once the packet is complete
    assign cmd_start_o = issue_state && !cmd_pend && !(state == S_PROG && pack_done_i);

    assign status_err    = status_i[ST_ERASE_ERR_BIT] || status_i[ST_PROG_ERR_BIT];
    assign pack_start    = state == S_IDLE && !erase_req_i && pack_req_i;
    assign pack_accept_o = pack_start && pack_num_match_i;
    assign fifo_flush_o  = pack_start && !pack_num_match_i;
    assign poll_wait_o   = state == S_POLL;
    assign block_next_o  = state == S_CHECK && status_i == STATUS_OK && !last_block_i;

    //////////////////////////////
    // sequencing and host acks

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state          <= S_IDLE;
            cmd_pend       <= 1'b0;
            erase_ack_o    <= 1'b0;
            erase_status_o <= '0;
            pack_ack_o     <= 1'b0;
            pack_err_o     <= 1'b0;
        end else begin
            if (cmd_start_o) begin
                cmd_pend <= 1'b1;
            end else if (cmd_done_i) begin
                cmd_pend <= 1'b0;
            end

            case (state)
                S_IDLE: begin
                    if (erase_req_i) begin
                        state <= S_CLR;
                    end else if (pack_accept_o) begin
                        state <= S_PROG;
                    end else if (fifo_flush_o) begin
                        state      <= S_PACK_END;
                        pack_ack_o <= 1'b1;
                        pack_err_o <= 1'b1;
                    end
                end
                S_CLR:       if (cmd_done_i) state <= S_ERASE;
                S_ERASE:     if (cmd_done_i) state <= S_POLL;
                S_POLL:      if (poll_due_i) state <= S_RD_STATUS;
                S_RD_STATUS: if (cmd_done_i) state <= S_CHECK;
                S_UNLOCK:    if (cmd_done_i) state <= S_CLR;
                S_CHECK: begin
                    if (!status_i[ST_READY_BIT]) begin
                        state <= S_POLL;
                    end else if (status_i == STATUS_OK && !last_block_i) begin
                        state <= S_CLR;
                    end else if (status_i[ST_LOCK_BIT] && !status_err) begin
                        state <= S_UNLOCK;
                    end else begin
                        // done, or aborted on an error
                        state          <= S_ERASE_END;
                        erase_ack_o    <= 1'b1;
                        erase_status_o <= status_i;
                    end
                end
                S_ERASE_END: begin
                    if (!erase_req_i) begin
                        state       <= S_IDLE;
                        erase_ack_o <= 1'b0;
                    end
                end
                S_PROG: begin
                    if (pack_done_i) begin
                        state      <= S_PACK_END;
                        pack_ack_o <= 1'b1;
                        pack_err_o <= 1'b0;
                    end
                end
                S_PACK_END: begin
                    if (!pack_req_i) begin
                        state      <= S_IDLE;
                        pack_ack_o <= 1'b0;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // the port accepts a new command only after the previous one completed
    a_start_spacing: assert property (@(posedge clk_i) disable iff (rst_i)
        cmd_start_o |=> !cmd_start_o);

endmodule

`default_nettype wire

// ==== source/flash_cmd_pkg.sv ====
`default_nettype none

package flash_cmd_pkg;

    // commands carried over the flash req/ack port
    typedef enum logic [2:0] {
        CMD_CLR_STATUS,
        CMD_BLOCK_ERASE,
        CMD_READ_STATUS,
        CMD_UNLOCK,
        CMD_PROGRAM
    } flash_cmd_t;

    typedef enum logic [3:0] {
        S_IDLE,
        S_CLR,
        S_ERASE,
        S_POLL,
        S_RD_STATUS,
        S_CHECK,
        S_UNLOCK,
        S_ERASE_END,
        S_PROG,
        S_PACK_END
    } upd_state_t;

    // status register layout
    localparam int ST_READY_BIT     = 7;
    localparam int ST_ERASE_ERR_BIT = 5;
    localparam int ST_PROG_ERR_BIT  = 4;
    localparam int ST_LOCK_BIT      = 1;

    localparam logic [7:0] STATUS_OK = 8'h80;

endpackage

`default_nettype wire

// ==== source/flash_geom_pkg.sv ====
`default_nettype none

package flash_geom_pkg;

    localparam int FLASH_ADDR_W     = 27;
    localparam int FLASH_DATA_W     = 16;
    localparam int HOST_DATA_W      = 32;

    // multiboot region, block size reduced for simulation
    localparam logic [FLASH_ADDR_W-1:0] REGION_BASE = 27'h40_0000;
    localparam logic [FLASH_ADDR_W-1:0] BLOCK_WORDS = 27'h100;
    localparam int ERASE_BLOCKS     = 4;
    localparam logic [FLASH_ADDR_W-1:0] LAST_BLOCK_ADDR =
        REGION_BASE + BLOCK_WORDS * FLASH_ADDR_W'(ERASE_BLOCKS - 1);

    // one packet is 8 host words, 16 flash words
    localparam int PACK_HOST_WORDS  = 8;
    localparam int PACK_FLASH_WORDS = 2 * PACK_HOST_WORDS;
    localparam int PACK_NUM_W       = 16;

    localparam int POLL_CYCLES      = 20;
    localparam int FIFO_DEPTH       = 16;

    // counter widths
    localparam int FIFO_PTR_W       = $clog2(FIFO_DEPTH);
    localparam int POLL_CNT_W       = $clog2(POLL_CYCLES);
    localparam int WORD_IDX_W       = $clog2(PACK_FLASH_WORDS);

endpackage

`default_nettype wire
